// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // 4 KB pages
    localparam int PAGE_BITS = 12;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // Page number and offset within a page
    typedef logic [31-PAGE_BITS:0] page_t;
    typedef logic [PAGE_BITS-1:0]  page_off_t;

    typedef enum logic [2:0] {
        EXC_NONE      = 3'd0,
        EXC_ITLB_MISS = 3'd1,
        EXC_DTLB_MISS = 3'd2,
        EXC_ILLEGAL   = 3'd3,
        EXC_RETURN    = 3'd4
    } exc_t;

    // PC generation to ITLB
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } fetch_req_t;

    // ITLB stage register to icache
    typedef struct packed {
        logic  valid;
        addr_t vpc;
        addr_t paddr;
        exc_t  exc;
    } xlate_t;

    // Packet toward decode
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
        exc_t   exc;
    } fetch_pkt_t;

    function automatic page_t page_num(addr_t a);
        return a[31:PAGE_BITS];
    endfunction

    function automatic page_off_t page_off(addr_t a);
        return a[PAGE_BITS-1:0];
    endfunction

endpackage

// ==== source/pc_gen.sv ====
`timescale 1ns/10ps
module pc_gen
    import fetch_pkg::*;
#(
    parameter addr_t INIT_ADDR     = 32'h1000,
    parameter int    FETCH_CREDITS = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       branch_taken,
    input  addr_t      new_pc,
    input  logic       trap_redirect,
    input  addr_t      trap_addr,
    input  logic       pc_write_disable,
    input  logic       dcache_stall,
    input  logic       busy,
    input  logic       credit_return,
    input  logic       delivered,
    output fetch_req_t req,
    output logic       flush,
    output addr_t      pc
);

    localparam int CNT_BITS = $clog2(FETCH_CREDITS + 1);

    logic [CNT_BITS-1:0] credits;
    logic [CNT_BITS-1:0] in_flight;
    logic                issue;

    // Either redirect kills everything younger than it
    assign flush = trap_redirect || branch_taken;

    // Outstanding packets never exceed the credits decode granted
    assign issue = (credits > in_flight) && !busy && !dcache_stall &&
                   !pc_write_disable && !flush;

    assign req.valid = issue;
    assign req.pc    = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= INIT_ADDR;
        end else if (trap_redirect) begin
            pc <= trap_addr;
        end else if (branch_taken) begin
            pc <= new_pc;
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits   <= CNT_BITS'(FETCH_CREDITS);
            in_flight <= '0;
        end else begin
            credits <= credits + CNT_BITS'(credit_return) - CNT_BITS'(delivered);
            if (flush) begin
                in_flight <= '0;
            end else begin
                in_flight <= in_flight + CNT_BITS'(issue) - CNT_BITS'(delivered);
            end
        end
    end

endmodule

// ==== source/priv_regs.sv ====
`timescale 1ns/10ps
module priv_regs
    import fetch_pkg::*;
#(
    parameter addr_t TRAP_ADDR = 32'h100
) (
    input  logic        clk,
    input  logic        reset,
    input  exc_t        rob_exc,
    input  addr_t       rob_fault_pc,
    input  addr_t       rob_fault_addr,
    input  logic        priv_write_enable,
    input  logic [2:0]  priv_rm_idx,
    input  logic [31:0] priv_write_data,
    output logic        trap_redirect,
    output addr_t       trap_addr,
    output logic        supervisor_mode,
    output logic [31:0] rm1
);

    // rm0 saved PC, rm1 fault address, rm2 cause
    logic [31:0] rm [8];

    assign rm1 = rm[1];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                rm[i] <= '0;
            end
            supervisor_mode <= 1'b1;
            trap_redirect   <= 1'b0;
            trap_addr       <= TRAP_ADDR;
        end else begin
            trap_redirect <= 1'b0;
            if (rob_exc == EXC_RETURN) begin
                supervisor_mode <= 1'b0;
                trap_redirect   <= 1'b1;
                trap_addr       <= rm[0];
            end else if (rob_exc != EXC_NONE) begin
                rm[0]           <= rob_fault_pc;
                rm[1]           <= rob_fault_addr;
                rm[2]           <= 32'(rob_exc);
                supervisor_mode <= 1'b1;
                trap_redirect   <= 1'b1;
                trap_addr       <= TRAP_ADDR;
            end else if (priv_write_enable) begin
                // Software write, lower priority than a trap event
                rm[priv_rm_idx] <= priv_write_data;
            end
        end
    end

endmodule

// ==== source/itlb.sv ====
`timescale 1ns/10ps
module itlb
    import fetch_pkg::*;
#(
    parameter int TLB_ENTRIES = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       hold,
    input  logic       supervisor_mode,
    input  fetch_req_t req,
    input  logic       tlb_write_enable,
    input  addr_t      tlb_vaddr,
    input  addr_t      tlb_paddr,
    output xlate_t     xlate
);

    localparam int PTR_BITS = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] entry_valid;
    page_t                  entry_vpn [TLB_ENTRIES];
    page_t                  entry_ppn [TLB_ENTRIES];
    logic [PTR_BITS-1:0]    victim;
    logic [PTR_BITS-1:0]    write_idx;
    logic                   write_match;
    logic                   lookup_hit;
    page_t                  lookup_ppn;
    addr_t                  paddr;
    exc_t                   exc;

    always_comb begin
        lookup_hit = 1'b0;
        lookup_ppn = '0;
        write_match = 1'b0;
        write_idx = victim;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (entry_valid[i] && entry_vpn[i] == page_num(req.pc)) begin
                lookup_hit = 1'b1;
                lookup_ppn = entry_ppn[i];
            end
            // Rewriting a page already present replaces it in place
            if (entry_valid[i] && entry_vpn[i] == page_num(tlb_vaddr)) begin
                write_match = 1'b1;
                write_idx = PTR_BITS'(i);
            end
        end
    end

    always_comb begin
        if (supervisor_mode) begin
            paddr = req.pc;
            exc = EXC_NONE;
        end else if (lookup_hit) begin
            paddr = {lookup_ppn, page_off(req.pc)};
            exc = EXC_NONE;
        end else begin
            paddr = '0;
            exc = EXC_ITLB_MISS;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            entry_valid <= '0;
            victim      <= '0;
        end else if (tlb_write_enable) begin
            entry_valid[write_idx] <= 1'b1;
            if (!write_match) begin
                victim <= (victim == PTR_BITS'(TLB_ENTRIES - 1)) ? '0 : victim + PTR_BITS'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_write_enable) begin
            entry_vpn[write_idx] <= page_num(tlb_vaddr);
            entry_ppn[write_idx] <= page_num(tlb_paddr);
        end
    end

    // Stage register, frozen while the cache is busy
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            xlate <= '0;
        end else if (flush) begin
            xlate.valid <= 1'b0;
        end else if (!hold) begin
            xlate <= '{valid: req.valid, vpc: req.pc, paddr: paddr, exc: exc};
        end
    end

endmodule

// ==== source/icache.sv ====
`timescale 1ns/10ps
module icache
    import fetch_pkg::*;
#(
    parameter int LINE_BITS   = 128,
    parameter int CACHE_LINES = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  xlate_t               xlate,
    input  logic [LINE_BITS-1:0] mem_read_data,
    input  logic                 mem_ready,
    output fetch_pkt_t           fetch,
    output logic                 busy,
    output logic                 mem_read_en,
    output logic                 mem_write_en,
    output addr_t                mem_addr,
    output logic [LINE_BITS-1:0] mem_write_data
);

    localparam int OFF_BITS = $clog2(LINE_BITS / 8);
    localparam int IDX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS = 32 - OFF_BITS - IDX_BITS;

    typedef enum logic {
        CACHE_LOOKUP,
        CACHE_REFILL
    } cache_state_t;

    cache_state_t         state;
    logic [CACHE_LINES-1:0] line_valid;
    logic [TAG_BITS-1:0]  tags  [CACHE_LINES];
    logic [LINE_BITS-1:0] lines [CACHE_LINES];

    logic [IDX_BITS-1:0]  idx;
    logic [TAG_BITS-1:0]  tag;
    logic                 hit;
    logic                 lookup_miss;
    instr_t               hit_word;

    addr_t                refill_addr;
    addr_t                refill_pc;
    logic                 refill_live;
    logic [IDX_BITS-1:0]  refill_idx;
    instr_t               refill_word;

    assign idx = xlate.paddr[OFF_BITS +: IDX_BITS];
    assign tag = xlate.paddr[31 -: TAG_BITS];
    assign hit = line_valid[idx] && tags[idx] == tag;
    assign hit_word = lines[idx][{xlate.paddr[OFF_BITS-1:2], 5'b0} +: 32];

    // Exception packets bypass the lookup and never miss
    assign lookup_miss = state == CACHE_LOOKUP && xlate.valid &&
                         xlate.exc == EXC_NONE && !hit;

    // Released in the fill cycle so the ITLB stage can advance
    assign busy = (state == CACHE_REFILL && !mem_ready) || lookup_miss;

    assign refill_idx  = refill_addr[OFF_BITS +: IDX_BITS];
    assign refill_word = mem_read_data[{refill_addr[OFF_BITS-1:2], 5'b0} +: 32];

    assign mem_read_en    = state == CACHE_REFILL;
    assign mem_addr       = {refill_addr[31:OFF_BITS], OFF_BITS'(0)};
    assign mem_write_en   = 1'b0;
    assign mem_write_data = '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= CACHE_LOOKUP;
            refill_live <= 1'b0;
            line_valid  <= '0;
            fetch       <= '0;
        end else begin
            case (state)
                CACHE_LOOKUP: begin
                    fetch.valid <= 1'b0;
                    if (xlate.valid && !flush) begin
                        if (xlate.exc != EXC_NONE) begin
                            fetch <= '{valid: 1'b1, pc: xlate.vpc, instr: '0, exc: xlate.exc};
                        end else if (hit) begin
                            fetch <= '{valid: 1'b1, pc: xlate.vpc, instr: hit_word,
                                       exc: EXC_NONE};
                        end else begin
                            state       <= CACHE_REFILL;
                            refill_live <= 1'b1;
                        end
                    end
                end
                CACHE_REFILL: begin
                    fetch.valid <= 1'b0;
                    // Flushed refill still lands in the array
                    if (flush) begin
                        refill_live <= 1'b0;
                    end
                    if (mem_ready) begin
                        line_valid[refill_idx] <= 1'b1;
                        state <= CACHE_LOOKUP;
                        fetch <= '{valid: refill_live && !flush, pc: refill_pc,
                                   instr: refill_word, exc: EXC_NONE};
                    end
                end
                default: state <= CACHE_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            refill_addr <= xlate.paddr;
            refill_pc   <= xlate.vpc;
        end
        if (state == CACHE_REFILL && mem_ready) begin
            tags[refill_idx]  <= refill_addr[31 -: TAG_BITS];
            lines[refill_idx] <= mem_read_data;
        end
    end

endmodule

// ==== source/stage_fetch.sv ====
`timescale 1ns/10ps
module stage_fetch
    import fetch_pkg::*;
#(
    parameter addr_t INIT_ADDR     = 32'h1000,
    parameter addr_t TRAP_ADDR     = 32'h100,
    parameter int    FETCH_CREDITS = 4,
    parameter int    TLB_ENTRIES   = 8,
    parameter int    LINE_BITS     = 128,
    parameter int    CACHE_LINES   = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 branch_taken,
    input  addr_t                new_pc,
    input  logic                 pc_write_disable,
    input  logic                 dcache_stall,
    input  logic                 credit_return,
    input  logic [LINE_BITS-1:0] mem_read_data,
    input  logic                 mem_ready,
    input  exc_t                 rob_exc,
    input  addr_t                rob_fault_pc,
    input  addr_t                rob_fault_addr,
    input  logic                 priv_write_enable,
    input  logic [2:0]           priv_rm_idx,
    input  logic [31:0]          priv_write_data,
    input  logic                 tlb_write_enable,
    input  addr_t                tlb_vaddr,
    input  addr_t                tlb_paddr,
    output fetch_pkt_t           fetch,
    output logic                 mem_read_en,
    output logic                 mem_write_en,
    output addr_t                mem_addr,
    output logic [LINE_BITS-1:0] mem_write_data,
    output logic [31:0]          rm1,
    output logic                 supervisor_mode
);

    fetch_req_t req;
    xlate_t     xlate;
    logic       flush;
    logic       busy;
    logic       trap_redirect;
    addr_t      trap_addr;

    pc_gen #(
        .INIT_ADDR    (INIT_ADDR),
        .FETCH_CREDITS(FETCH_CREDITS)
    ) u_pc_gen (
        .clk             (clk),
        .reset           (reset),
        .branch_taken    (branch_taken),
        .new_pc          (new_pc),
        .trap_redirect   (trap_redirect),
        .trap_addr       (trap_addr),
        .pc_write_disable(pc_write_disable),
        .dcache_stall    (dcache_stall),
        .busy            (busy),
        .credit_return   (credit_return),
        .delivered       (fetch.valid),
        .req             (req),
        .flush           (flush),
        .pc              ()
    );

    priv_regs #(
        .TRAP_ADDR(TRAP_ADDR)
    ) u_priv_regs (
        .clk              (clk),
        .reset            (reset),
        .rob_exc          (rob_exc),
        .rob_fault_pc     (rob_fault_pc),
        .rob_fault_addr   (rob_fault_addr),
        .priv_write_enable(priv_write_enable),
        .priv_rm_idx      (priv_rm_idx),
        .priv_write_data  (priv_write_data),
        .trap_redirect    (trap_redirect),
        .trap_addr        (trap_addr),
        .supervisor_mode  (supervisor_mode),
        .rm1              (rm1)
    );

    itlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_itlb (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .hold            (busy),
        .supervisor_mode (supervisor_mode),
        .req             (req),
        .tlb_write_enable(tlb_write_enable),
        .tlb_vaddr       (tlb_vaddr),
        .tlb_paddr       (tlb_paddr),
        .xlate           (xlate)
    );

    icache #(
        .LINE_BITS  (LINE_BITS),
        .CACHE_LINES(CACHE_LINES)
    ) u_icache (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .xlate         (xlate),
        .mem_read_data (mem_read_data),
        .mem_ready     (mem_ready),
        .fetch         (fetch),
        .busy          (busy),
        .mem_read_en   (mem_read_en),
        .mem_write_en  (mem_write_en),
        .mem_addr      (mem_addr),
        .mem_write_data(mem_write_data)
    );

endmodule

// ==== tb/fetch_tests.svh ====
// Fixed user page used by the trap and translation tests
localparam addr_t FAULT_PC   = 32'h0004_0010;
localparam addr_t FAULT_ADDR = 32'h0000_0bad;
localparam addr_t MAP_PAGE   = 32'h0000_3000;

task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
endtask

task automatic wait_packet(output fetch_pkt_t pkt);
    int waited;
    waited = 0;
    while (fetch_q.size() == 0 && waited < 200) begin
        @(posedge clk);
        #1;
        waited++;
    end
    if (fetch_q.size() == 0) begin
        $display("No fetch packet arrived within 200 cycles");
        $display("Verification failed");
        $fatal(1, "Fetch packet timeout");
    end else begin
        pkt = fetch_q.pop_front();
    end
endtask

task automatic expect_packet(input addr_t exp_pc, input instr_t exp_instr, input exc_t exp_exc);
    fetch_pkt_t pkt;
    wait_packet(pkt);
    check_eq(pkt.pc, exp_pc, "packet pc");
    check_eq(pkt.instr, exp_instr, "packet instruction");
    check_eq(32'(pkt.exc), 32'(exp_exc), "packet exception");
endtask

task automatic give_credits(input int n);
    repeat (n) begin
        @(posedge clk);
        grant_req <= 1'b1;
    end
    @(posedge clk);
    grant_req <= 1'b0;
endtask

// Old path packets seen up to the flush edge are discarded
task automatic redirect_branch(input addr_t target);
    @(posedge clk);
    branch_taken <= 1'b1;
    new_pc       <= target;
    @(posedge clk);
    branch_taken <= 1'b0;
    #1;
    fetch_q.delete();
endtask

task automatic rob_event(input exc_t exc, input addr_t fpc, input addr_t faddr);
    @(posedge clk);
    rob_exc        <= exc;
    rob_fault_pc   <= fpc;
    rob_fault_addr <= faddr;
    @(posedge clk);
    rob_exc <= EXC_NONE;
    // Redirect lands one edge after the event is registered
    @(posedge clk);
    #1;
    fetch_q.delete();
endtask

task automatic startup_fetch_test();
    @(posedge clk);
    auto_credit <= 1'b1;
    next_pc = INIT_ADDR;
    repeat (12) begin
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
    end
    check_eq(32'(supervisor_mode), 32'd1, "supervisor mode after reset");
    check_eq(mem_req_q[0], INIT_ADDR, "first line request");
    check_eq(mem_req_q[1], INIT_ADDR + 32'h10, "second line request");
    check_eq(mem_req_q[2], INIT_ADDR + 32'h20, "third line request");
    check_eq(32'(mem_req_q.size() <= 4), 32'd1, "one memory request per line");
endtask

task automatic credit_flow_test();
    @(posedge clk);
    auto_credit <= 1'b0;
    idle_cycles(50);
    while (fetch_q.size() > 0) begin
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
    end
    give_credits(FETCH_CREDITS);
    repeat (FETCH_CREDITS) begin
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
    end
    idle_cycles(50);
    check_eq(32'(fetch_q.size()), 32'd0, "packets beyond granted credits");
    repeat (3) begin
        give_credits(1);
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
        idle_cycles(20);
        check_eq(32'(fetch_q.size()), 32'd0, "packets after a single credit");
    end
endtask

task automatic branch_redirect_test();
    @(posedge clk);
    auto_credit <= 1'b1;
    give_credits(FETCH_CREDITS);
    repeat (2) begin
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
    end
    redirect_branch(32'h2000);
    next_pc = 32'h2000;
    repeat (8) begin
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
    end
endtask

task automatic trap_return_test();
    rob_event(EXC_ILLEGAL, FAULT_PC, FAULT_ADDR);
    check_eq(rm1, FAULT_ADDR, "fault address register");
    check_eq(32'(supervisor_mode), 32'd1, "supervisor mode after trap");
    next_pc = TRAP_ADDR;
    repeat (4) begin
        expect_packet(next_pc, word_at(next_pc), EXC_NONE);
        next_pc += 32'd4;
    end
    @(posedge clk);
    tlb_write_enable <= 1'b1;
    tlb_vaddr        <= FAULT_PC;
    tlb_paddr        <= MAP_PAGE;
    @(posedge clk);
    tlb_write_enable <= 1'b0;
    rob_event(EXC_RETURN, '0, '0);
    check_eq(32'(supervisor_mode), 32'd0, "supervisor mode after return");
    expect_packet(FAULT_PC, word_at(MAP_PAGE | (FAULT_PC & 32'hfff)), EXC_NONE);
    next_pc = FAULT_PC + 32'd4;
endtask

task automatic user_translation_test();
    int reqs_before;
    repeat (6) begin
        expect_packet(next_pc, word_at(MAP_PAGE | (next_pc & 32'hfff)), EXC_NONE);
        next_pc += 32'd4;
    end
    redirect_branch(32'h0009_0000);
    next_pc = 32'h0009_0000;
    expect_packet(next_pc, '0, EXC_ITLB_MISS);
    next_pc += 32'd4;
    reqs_before = mem_req_q.size();
    repeat (4) begin
        expect_packet(next_pc, '0, EXC_ITLB_MISS);
        check_eq(32'(mem_read_en), 32'd0, "memory read on an unmapped page");
        next_pc += 32'd4;
    end
    check_eq(32'(mem_req_q.size()), 32'(reqs_before), "memory requests on ITLB miss");
endtask

// ==== tb/fetch_tb.sv ====
`timescale 1ns/10ps
module fetch_tb
    import fetch_pkg::*;
;

    localparam addr_t INIT_ADDR     = 32'h1000;
    localparam addr_t TRAP_ADDR     = 32'h100;
    localparam int    FETCH_CREDITS = 4;
    localparam int    LINE_BITS     = 128;
    localparam int    CLK_HALF      = 4;
    localparam int    NUM_TESTS     = 5;
    localparam addr_t WORD_KEY      = 32'h5a5a_0000;

    logic                 clk;
    logic                 reset;
    logic                 branch_taken;
    addr_t                new_pc;
    logic                 pc_write_disable;
    logic                 dcache_stall;
    logic                 credit_return;
    logic [LINE_BITS-1:0] mem_read_data;
    logic                 mem_ready;
    exc_t                 rob_exc;
    addr_t                rob_fault_pc;
    addr_t                rob_fault_addr;
    logic                 priv_write_enable;
    logic [2:0]           priv_rm_idx;
    logic [31:0]          priv_write_data;
    logic                 tlb_write_enable;
    addr_t                tlb_vaddr;
    addr_t                tlb_paddr;
    fetch_pkt_t           fetch;
    logic                 mem_read_en;
    logic                 mem_write_en;
    addr_t                mem_addr;
    logic [LINE_BITS-1:0] mem_write_data;
    logic [31:0]          rm1;
    logic                 supervisor_mode;

    // Memory model state
    integer     seed;
    logic       mem_busy;
    logic [1:0] mem_delay;
    addr_t      mem_req_q [$];

    // Decode credit model state
    fetch_pkt_t fetch_q [$];
    logic       auto_credit;
    logic       grant_req;
    int         owed;
    int         owed_next;
    addr_t      next_pc;

    stage_fetch #(
        .INIT_ADDR    (INIT_ADDR),
        .TRAP_ADDR    (TRAP_ADDR),
        .FETCH_CREDITS(FETCH_CREDITS),
        .LINE_BITS    (LINE_BITS)
    ) DUT (
        .clk              (clk),
        .reset            (reset),
        .branch_taken     (branch_taken),
        .new_pc           (new_pc),
        .pc_write_disable (pc_write_disable),
        .dcache_stall     (dcache_stall),
        .credit_return    (credit_return),
        .mem_read_data    (mem_read_data),
        .mem_ready        (mem_ready),
        .rob_exc          (rob_exc),
        .rob_fault_pc     (rob_fault_pc),
        .rob_fault_addr   (rob_fault_addr),
        .priv_write_enable(priv_write_enable),
        .priv_rm_idx      (priv_rm_idx),
        .priv_write_data  (priv_write_data),
        .tlb_write_enable (tlb_write_enable),
        .tlb_vaddr        (tlb_vaddr),
        .tlb_paddr        (tlb_paddr),
        .fetch            (fetch),
        .mem_read_en      (mem_read_en),
        .mem_write_en     (mem_write_en),
        .mem_addr         (mem_addr),
        .mem_write_data   (mem_write_data),
        .rm1              (rm1),
        .supervisor_mode  (supervisor_mode)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic instr_t word_at(addr_t a);
        return a ^ WORD_KEY;
    endfunction

    function automatic logic [LINE_BITS-1:0] line_image(addr_t base);
        logic [LINE_BITS-1:0] line;
        for (int i = 0; i < LINE_BITS / 32; i++) begin
            line[32*i +: 32] = word_at(base + 32'(4 * i));
        end
        return line;
    endfunction

    // Answers each line request after 1 to 4 cycles
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
            mem_delay <= '0;
        end else begin
            // Read-only port
            check_eq(32'(mem_write_en), 32'd0, "memory write enable");
            check_eq(32'(|mem_write_data), 32'd0, "memory write data");
            mem_ready <= 1'b0;
            if (!mem_busy) begin
                if (mem_read_en && !mem_ready) begin
                    mem_busy  <= 1'b1;
                    mem_delay <= 2'($random(seed));
                    mem_req_q.push_back(mem_addr);
                end
            end else if (mem_delay == 2'd0) begin
                mem_ready     <= 1'b1;
                mem_read_data <= line_image(mem_addr);
                mem_busy      <= 1'b0;
            end else begin
                mem_delay <= mem_delay - 2'd1;
            end
        end
    end

    // Decode side, returns at most one credit per cycle and keeps the rest owed
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            owed          <= 0;
            credit_return <= 1'b0;
        end else begin
            if (fetch.valid) begin
                fetch_q.push_back(fetch);
            end
            owed_next = owed + int'(grant_req) + int'(auto_credit && fetch.valid);
            if (owed_next > 0) begin
                credit_return <= 1'b1;
                owed          <= owed_next - 1;
            end else begin
                credit_return <= 1'b0;
                owed          <= owed_next;
            end
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    `include "fetch_tests.svh"

    initial begin
        $display("Watchdog armed for %0d cycles", NUM_TESTS * 200);
        #(NUM_TESTS * 200 * 2 * CLK_HALF);
        $display("Verification failed");
        $fatal(1, "The simulation ran out of time before all tests finished");
    end

    initial begin
        seed              = 32'hc092;
        clk               = 1'b0;
        reset             = 1'b1;
        branch_taken      = 1'b0;
        new_pc            = '0;
        pc_write_disable  = 1'b0;
        dcache_stall      = 1'b0;
        credit_return     = 1'b0;
        mem_read_data     = '0;
        mem_ready         = 1'b0;
        rob_exc           = EXC_NONE;
        rob_fault_pc      = '0;
        rob_fault_addr    = '0;
        priv_write_enable = 1'b0;
        priv_rm_idx       = '0;
        priv_write_data   = '0;
        tlb_write_enable  = 1'b0;
        tlb_vaddr         = '0;
        tlb_paddr         = '0;
        auto_credit       = 1'b0;
        grant_req         = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        startup_fetch_test();
        credit_flow_test();
        branch_redirect_test();
        trap_return_test();
        user_translation_test();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+tb
source/fetch_pkg.sv
source/pc_gen.sv
source/priv_regs.sv
source/itlb.sv
source/icache.sv
source/stage_fetch.sv
tb/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the fetch testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f src.f \
    --top-module fetch_tb \
    -Mdir obj_dir

./obj_dir/Vfetch_tb
